// ==== files.f ====
design/bus_pkg.sv
design/addr_map_pkg.sv
design/xbus_if.sv
design/busint.sv
design/xbus_ram.sv
design/xbus_dma.sv
design/xbus_io.sv
design/bus_top.sv
verif/busint_sva.sv
verif/tb_bus_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_bus_top
FILELIST  := files.f
VFLAGS    := --binary --timing --assert -j 0
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// ==== verif/tb_bus_top.sv ====
/*
 * tb_bus_top
 * directed testbench for the bus interface, with an sdram model of
 * random latency, cpu read/write tasks and checks of dram, timeout,
 * dma fill, keyboard and mode register behavior
 */

`timescale 1ns/100ps

module tb_bus_top;

   localparam int TIMEOUT_BITS   = 6;
   localparam int DMA_COUNT_BITS = 8;
   localparam int MAX_CYCLES     = 20000;
   localparam int TIMEOUT_CYCLES = (1 << TIMEOUT_BITS) - 1;
   localparam bus_pkg::addr_t UNMAPPED = 22'o17500000;

   logic           mclk;
   logic           reset;
   bus_pkg::addr_t addr;
   bus_pkg::word_t busin;
   logic           req;
   logic           write;
   bus_pkg::word_t busout;
   logic           ack;
   logic           load;
   logic           interrupt;
   bus_pkg::addr_t sdram_addr;
   bus_pkg::word_t sdram_data_out;
   bus_pkg::word_t sdram_data_in;
   logic           sdram_req;
   logic           sdram_write;
   logic           sdram_done;
   bus_pkg::kb_t   kb_data;
   logic           kb_ready;
   logic           promdisable;

   bus_pkg::word_t sdram_mem [bus_pkg::addr_t];
   bus_pkg::word_t expected_mem [bus_pkg::addr_t];
   int latency_table [256];
   int latency_index;
   int errors;
   int cycles;
   int seed_draw;

   bus_top #(
      .TIMEOUT_BITS(TIMEOUT_BITS),
      .DMA_COUNT_BITS(DMA_COUNT_BITS)
   ) u_bus_top (.*);

   initial
   begin
      mclk = 1'b0;
      forever #20 mclk = ~mclk;
   end

   // run limit, well above the length of all tests together
   initial
   begin
      cycles = 0;
      forever
      begin
         @(posedge mclk);
         cycles++;
         if (cycles >= MAX_CYCLES)
         begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "cycle limit reached");
         end
      end
   end

   // unwritten words read back as a pattern of the whole address
   function automatic bus_pkg::word_t fill_word(input bus_pkg::addr_t a);
      return {a[9:0], a} ^ 32'h3c5a_96e1;
   endfunction

   // sdram model, done comes 1 to 4 cycles after the request
   initial
   begin
      int latency;
      bus_pkg::addr_t a;
      bus_pkg::word_t rd;
      latency_index = 0;
      sdram_done    = 1'b0;
      sdram_data_in = '0;
      forever
      begin
         @(posedge mclk);
         #2;
         if (sdram_req)
         begin
            latency = latency_table[latency_index % 256];
            latency_index++;
            a = sdram_addr;
            if (sdram_write)
               sdram_mem[a] = sdram_data_out;
            rd = sdram_mem.exists(a) ? sdram_mem[a] : fill_word(a);
            repeat (latency - 1)
            begin
               @(posedge mclk);
               #2;
            end
            sdram_data_in = rd;
            sdram_done    = 1'b1;
            @(posedge mclk);
            #2;
            sdram_done = 1'b0;
         end
      end
   end

   task automatic check_eq(input bus_pkg::word_t actual, input bus_pkg::word_t expected,
                           input string msg);
      if (actual !== expected)
      begin
         errors++;
         $display("mismatch at %0t ns: %s, got %h, expected %h",
                  $time, msg, actual, expected);
         $display("SOME TESTS FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   // one cpu cycle, request held until the arbiter acks
   task automatic cpu_access(input bus_pkg::addr_t a, input bus_pkg::word_t d,
                             input logic wr, output bus_pkg::word_t rd);
      @(posedge mclk);
      #2;
      addr  = a;
      busin = d;
      write = wr;
      req   = 1'b1;
      @(negedge mclk);
      while (!ack)
         @(negedge mclk);
      rd = busout;
      check_eq(bus_pkg::word_t'(load), bus_pkg::word_t'(!wr), "load with cpu ack");
      @(posedge mclk);
      #2;
      req = 1'b0;
   endtask

   task automatic cpu_write(input bus_pkg::addr_t a, input bus_pkg::word_t d);
      bus_pkg::word_t unused;
      cpu_access(a, d, 1'b1, unused);
   endtask

   task automatic cpu_read(input bus_pkg::addr_t a, output bus_pkg::word_t d);
      cpu_access(a, '0, 1'b0, d);
   endtask

   function automatic bus_pkg::addr_t dma_reg(input logic [1:0] offset);
      return {addr_map_pkg::dma_base[21:2], offset};
   endfunction

   function automatic bus_pkg::addr_t io_reg(input logic [1:0] offset);
      return {addr_map_pkg::io_base[21:2], offset};
   endfunction

   task automatic dram_write_read();
      bus_pkg::addr_t a;
      bus_pkg::word_t d;
      bus_pkg::word_t rd;
      expected_mem.delete();
      repeat (16)
      begin
         a = bus_pkg::addr_t'($urandom_range(32'(addr_map_pkg::dram_top), 0));
         d = $urandom;
         cpu_write(a, d);
         expected_mem[a] = d;
      end
      foreach (expected_mem[k])
      begin
         cpu_read(k, rd);
         check_eq(rd, expected_mem[k], "dram readback");
      end
   endtask

   task automatic unmapped_access();
      bus_pkg::word_t rd;
      int start;
      start = cycles;
      cpu_read(UNMAPPED, rd);
      check_eq(rd, '0, "unmapped read data");
      check_eq(bus_pkg::word_t'(cycles - start >= TIMEOUT_CYCLES), 32'd1,
               "unmapped read acked before the timeout");
      cpu_write(UNMAPPED, 32'hdead_beef);
   endtask

   task automatic start_fill(input bus_pkg::addr_t base, input int count,
                             input bus_pkg::word_t pattern, input bus_pkg::word_t cmd);
      cpu_write(dma_reg(addr_map_pkg::dma_addr), {10'd0, base});
      cpu_write(dma_reg(addr_map_pkg::dma_count), bus_pkg::word_t'(count));
      cpu_write(dma_reg(addr_map_pkg::dma_pattern), pattern);
      cpu_write(dma_reg(addr_map_pkg::dma_cmd), cmd);
   endtask

   task automatic dma_fill();
      bus_pkg::addr_t base;
      bus_pkg::word_t pattern;
      bus_pkg::word_t rd;
      int count;
      base    = 22'o00400000;
      pattern = 32'h5100_0000;
      count   = 12;
      // start bit plus interrupt enable
      start_fill(base, count, pattern, 32'h3);
      @(negedge mclk);
      while (!interrupt)
         @(negedge mclk);
      cpu_read(dma_reg(addr_map_pkg::dma_cmd), rd);
      check_eq(bus_pkg::word_t'(rd[2]), 32'd1, "dma done flag");
      for (int i = 0; i < count; i++)
      begin
         cpu_read(base + bus_pkg::addr_t'(i), rd);
         check_eq(rd, pattern + bus_pkg::word_t'(i), "dma fill data");
      end
   endtask

   task automatic dma_busy_read();
      bus_pkg::addr_t base;
      bus_pkg::word_t pattern;
      bus_pkg::word_t rd;
      int count;
      cpu_write(dma_reg(addr_map_pkg::dma_cmd), 32'h0);
      check_eq(bus_pkg::word_t'(interrupt), 32'd0, "interrupt after command write");
      base    = 22'o01200000;
      pattern = 32'ha700_0040;
      count   = 40;
      start_fill(base, count, pattern, 32'h1);
      // wait until the engine owns the bus
      @(negedge mclk);
      while (!sdram_req)
         @(negedge mclk);
      cpu_read(base + bus_pkg::addr_t'(count - 1), rd);
      check_eq(rd, pattern + bus_pkg::word_t'(count - 1), "read behind dma burst");
      cpu_read(dma_reg(addr_map_pkg::dma_cmd), rd);
      check_eq(bus_pkg::word_t'(rd[2]), 32'd1, "burst done after cpu read");
      check_eq(bus_pkg::word_t'(interrupt), 32'd0, "no interrupt when disabled");
   endtask

   task automatic keyboard_key();
      bus_pkg::kb_t code;
      bus_pkg::word_t rd;
      code = 16'h1c2b;
      @(posedge mclk);
      #2;
      kb_data  = code;
      kb_ready = 1'b1;
      @(posedge mclk);
      #2;
      kb_ready = 1'b0;
      @(negedge mclk);
      check_eq(bus_pkg::word_t'(interrupt), 32'd1, "keyboard interrupt");
      cpu_read(io_reg(addr_map_pkg::io_status), rd);
      check_eq(rd, 32'd1, "keyboard ready status");
      cpu_read(io_reg(addr_map_pkg::io_kbdata), rd);
      check_eq(rd, {16'd0, code}, "keyboard code");
      check_eq(bus_pkg::word_t'(interrupt), 32'd0, "interrupt after kbdata read");
   endtask

   task automatic mode_promdisable();
      cpu_write(io_reg(addr_map_pkg::io_mode), 32'd1);
      check_eq(bus_pkg::word_t'(promdisable), 32'd1, "promdisable set");
      cpu_write(io_reg(addr_map_pkg::io_mode), 32'd0);
      check_eq(bus_pkg::word_t'(promdisable), 32'd0, "promdisable cleared");
   endtask

   initial
   begin
      errors    = 0;
      seed_draw = $urandom(54);
      foreach (latency_table[i])
         latency_table[i] = $urandom_range(4, 1);
      reset    = 1'b1;
      addr     = '0;
      busin    = '0;
      req      = 1'b0;
      write    = 1'b0;
      kb_data  = '0;
      kb_ready = 1'b0;
      repeat (4) @(posedge mclk);
      #2;
      reset = 1'b0;
      dram_write_read();
      unmapped_access();
      dma_fill();
      dma_busy_read();
      keyboard_key();
      mode_promdisable();
      if (errors == 0)
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
      else
      begin
         $display("SOME TESTS FAILED");
         $fatal(1, "checks failed");
      end
   end

endmodule

// ==== verif/busint_sva.sv ====
/*
 * busint_sva
 * handshake checks on the bus arbiter and the slaves it serves,
 * bound into busint
 */

`timescale 1ns/100ps

module busint_sva (
   input logic mclk,
   input logic reset,
   input logic timed_out,
   input logic ram_decode,
   input logic dma_regs_decode,
   input logic io_decode,
   input logic ram_req,
   input logic ram_ack,
   input logic dma_req,
   input logic dma_ack,
   input logic grant
);

   // a decoded device always answers before the bus timeout
   timeout_unmapped_only: assert property (@(posedge mclk) disable iff (reset)
      timed_out |-> !(ram_decode || dma_regs_decode || io_decode))
      else $error("bus timeout on a decoded address");

   // memory ack stays up while its request is held
   ram_ack_held: assert property (@(posedge mclk) disable iff (reset)
      (ram_ack && ram_req) |=> ram_ack)
      else $error("memory ack dropped while req still high");

   // the dma master asks for a word only inside its grant
   dma_req_in_grant: assert property (@(posedge mclk) disable iff (reset)
      dma_req |-> grant)
      else $error("dma word request outside the grant");

   dma_req_held: assert property (@(posedge mclk) disable iff (reset)
      (dma_req && !dma_ack) |=> dma_req)
      else $error("dma word request dropped before its ack");

endmodule

bind busint busint_sva u_busint_sva (
   .mclk(mclk),
   .reset(reset),
   .timed_out(timed_out),
   .ram_decode(ram.decode),
   .dma_regs_decode(dma_regs.decode),
   .io_decode(io.decode),
   .ram_req(ram.req),
   .ram_ack(ram.ack),
   .dma_req(dma.req),
   .dma_ack(dma.ack),
   .grant(dma.grant)
);

// ==== design/bus_top.sv ====
/*
 * bus_top
 * bus interface top level, connects the arbiter to the
 * memory bridge, the dma fill engine and the i/o block
 */

`timescale 1ns/100ps

module bus_top #(
   parameter int TIMEOUT_BITS   = 6,
   parameter int DMA_COUNT_BITS = 8
) (
   input  logic            mclk,
   input  logic            reset,
   input  bus_pkg::addr_t  addr,
   input  bus_pkg::word_t  busin,
   input  logic            req,
   input  logic            write,
   output bus_pkg::word_t  busout,
   output logic            ack,
   output logic            load,
   output logic            interrupt,
   output bus_pkg::addr_t  sdram_addr,
   output bus_pkg::word_t  sdram_data_out,
   input  bus_pkg::word_t  sdram_data_in,
   output logic            sdram_req,
   output logic            sdram_write,
   input  logic            sdram_done,
   input  bus_pkg::kb_t    kb_data,
   input  logic            kb_ready,
   output logic            promdisable
);

   logic irq_dma;
   logic irq_io;

   xbus_if ram_bus ();
   xbus_if dma_bus ();
   xbus_if io_bus ();
   dma_if  dma_link ();

   busint #(.TIMEOUT_BITS(TIMEOUT_BITS)) u_busint (
      .mclk(mclk), .reset(reset),
      .addr(addr), .busin(busin), .req(req), .write(write),
      .busout(busout), .ack(ack), .load(load), .interrupt(interrupt),
      .ram(ram_bus), .dma_regs(dma_bus), .io(io_bus), .dma(dma_link),
      .irq_dma(irq_dma), .irq_io(irq_io)
   );

   xbus_ram u_ram (
      .mclk(mclk), .reset(reset), .bus(ram_bus),
      .sdram_addr(sdram_addr), .sdram_data_out(sdram_data_out),
      .sdram_data_in(sdram_data_in), .sdram_req(sdram_req),
      .sdram_write(sdram_write), .sdram_done(sdram_done)
   );

   xbus_dma #(.DMA_COUNT_BITS(DMA_COUNT_BITS)) u_dma (
      .mclk(mclk), .reset(reset), .regs(dma_bus), .dma(dma_link),
      .interrupt(irq_dma)
   );

   xbus_io u_io (
      .mclk(mclk), .reset(reset), .bus(io_bus),
      .kb_data(kb_data), .kb_ready(kb_ready),
      .promdisable(promdisable), .interrupt(irq_io)
   );

endmodule

// ==== design/xbus_io.sv ====
/*
 * xbus_io
 * keyboard latch with ready status and interrupt,
 * plus the mode register that holds promdisable
 */

`timescale 1ns/100ps

module xbus_io (
   input  logic          mclk,
   input  logic          reset,
   xbus_if.slave         bus,
   input  bus_pkg::kb_t  kb_data,
   input  logic          kb_ready,
   output logic          promdisable,
   output logic          interrupt
);

   bus_pkg::kb_t   kb_q;
   bus_pkg::word_t mode_q;
   logic ready_q;
   logic ack_q;
   logic first;

   assign bus.decode = (bus.addr[21:2] == addr_map_pkg::io_base[21:2]);
   assign first      = bus.req && !ack_q;

   always_comb
   begin
      case (bus.addr[1:0])
         addr_map_pkg::io_kbdata: bus.rdata = {16'd0, kb_q};
         addr_map_pkg::io_status: bus.rdata = {31'd0, ready_q};
         addr_map_pkg::io_mode:   bus.rdata = mode_q;
         default:                 bus.rdata = '0;
      endcase
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         ack_q   <= 1'b0;
         ready_q <= 1'b0;
         mode_q  <= '0;
      end
      else
      begin
         ack_q <= bus.req;
         // a fresh key wins over the read that clears the flag
         if (kb_ready)
            ready_q <= 1'b1;
         else if (first && !bus.write && bus.addr[1:0] == addr_map_pkg::io_kbdata)
            ready_q <= 1'b0;
         if (first && bus.write && bus.addr[1:0] == addr_map_pkg::io_mode)
            mode_q <= bus.wdata;
      end
   end

   always_ff @(posedge mclk)
   begin
      if (kb_ready)
         kb_q <= kb_data;
   end

   assign bus.ack     = ack_q;
   assign promdisable = mode_q[0];
   assign interrupt   = ready_q;

endmodule

// ==== design/xbus_dma.sv ====
/*
 * xbus_dma
 * dma fill engine, stands in for the disk controller
 * takes the bus and writes a counting pattern into memory,
 * interrupts when the burst is done
 */

`timescale 1ns/100ps

module xbus_dma #(
   parameter int DMA_COUNT_BITS = 8
) (
   input  logic  mclk,
   input  logic  reset,
   xbus_if.slave regs,
   dma_if.master dma,
   output logic  interrupt
);

   bus_pkg::addr_t addr_q;
   bus_pkg::word_t pattern_q;
   logic [DMA_COUNT_BITS-1:0] count_q;
   logic [DMA_COUNT_BITS-1:0] index_q;

   logic irq_en_q;
   logic running_q;
   logic done_q;
   logic irq_q;
   logic req_q;
   logic ack_q;
   logic reg_write;
   logic last_word;

   assign regs.decode = (regs.addr[21:2] == addr_map_pkg::dma_base[21:2]);

   // register access happens once, on the first cycle of the request
   assign reg_write = regs.req && !ack_q && regs.write;
   assign last_word = (index_q == count_q - 1'b1);

   always_comb
   begin
      case (regs.addr[1:0])
         addr_map_pkg::dma_cmd:     regs.rdata = {29'd0, done_q, irq_en_q, running_q};
         addr_map_pkg::dma_addr:    regs.rdata = {10'd0, addr_q};
         addr_map_pkg::dma_count:   regs.rdata = bus_pkg::word_t'(count_q);
         addr_map_pkg::dma_pattern: regs.rdata = pattern_q;
         default:                   regs.rdata = '0;
      endcase
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         ack_q     <= 1'b0;
         irq_en_q  <= 1'b0;
         running_q <= 1'b0;
         done_q    <= 1'b0;
         irq_q     <= 1'b0;
         req_q     <= 1'b0;
         index_q   <= '0;
      end
      else
      begin
         ack_q <= regs.req;

         // burst sequencer, one req/ack pair per word
         if (running_q)
         begin
            if (req_q && dma.ack)
            begin
               req_q <= 1'b0;
               if (last_word)
               begin
                  running_q <= 1'b0;
                  done_q    <= 1'b1;
                  irq_q     <= irq_en_q;
               end
               else
                  index_q <= index_q + 1'b1;
            end
            else if (dma.grant && !req_q)
               req_q <= 1'b1;
         end

         if (reg_write && regs.addr[1:0] == addr_map_pkg::dma_cmd)
         begin
            irq_en_q <= regs.wdata[1];
            done_q   <= 1'b0;
            irq_q    <= 1'b0;
            if (regs.wdata[0] && !running_q)
            begin
               index_q <= '0;
               // an empty burst finishes straight away
               if (count_q != '0)
                  running_q <= 1'b1;
               else
               begin
                  done_q <= 1'b1;
                  irq_q  <= regs.wdata[1];
               end
            end
         end
      end
   end

   always_ff @(posedge mclk)
   begin
      if (reg_write && regs.addr[1:0] == addr_map_pkg::dma_addr)
         addr_q <= regs.wdata[21:0];
      if (reg_write && regs.addr[1:0] == addr_map_pkg::dma_count)
         count_q <= regs.wdata[DMA_COUNT_BITS-1:0];
      if (reg_write && regs.addr[1:0] == addr_map_pkg::dma_pattern)
         pattern_q <= regs.wdata;
   end

   assign regs.ack = ack_q;

   assign dma.busreq = running_q;
   assign dma.req    = req_q;
   assign dma.write  = 1'b1;
   assign dma.addr   = addr_q + bus_pkg::addr_t'(index_q);
   assign dma.wdata  = pattern_q + bus_pkg::word_t'(index_q);

   assign interrupt = irq_q;

endmodule

// ==== design/xbus_ram.sv ====
/*
 * xbus_ram
 * bridge from the slave bus to the sdram request/done port,
 * one sdram access per bus request
 */

`timescale 1ns/100ps

module xbus_ram (
   input  logic            mclk,
   input  logic            reset,
   xbus_if.slave           bus,
   output bus_pkg::addr_t  sdram_addr,
   output bus_pkg::word_t  sdram_data_out,
   input  bus_pkg::word_t  sdram_data_in,
   output logic            sdram_req,
   output logic            sdram_write,
   input  logic            sdram_done
);

   logic busy;
   logic ack_q;
   logic start;
   bus_pkg::word_t rdata_q;

   assign bus.decode = (bus.addr <= addr_map_pkg::dram_top);

   // new access only once the previous ack has been taken down
   assign start = bus.req && bus.decode && !busy && !ack_q;

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         sdram_req   <= 1'b0;
         sdram_write <= 1'b0;
         busy        <= 1'b0;
         ack_q       <= 1'b0;
      end
      else
      begin
         sdram_req <= start;
         if (start)
         begin
            sdram_write <= bus.write;
            busy        <= 1'b1;
         end
         if (busy && sdram_done)
         begin
            busy  <= 1'b0;
            ack_q <= 1'b1;
         end
         else if (!bus.req)
            ack_q <= 1'b0;
      end
   end

   always_ff @(posedge mclk)
   begin
      if (start)
      begin
         sdram_addr     <= bus.addr;
         sdram_data_out <= bus.wdata;
      end
      if (busy && sdram_done)
         rdata_q <= sdram_data_in;
   end

   assign bus.rdata = rdata_q;
   assign bus.ack   = ack_q;

endmodule

// ==== design/busint.sv ====
/*
 * busint
 * bus arbiter between the cpu and the dma master, address routing to
 * the slaves, read data select, ack/load generation and bus timeout
 */

`timescale 1ns/100ps

module busint #(
   parameter int TIMEOUT_BITS = 6
) (
   input  logic            mclk,
   input  logic            reset,
   input  bus_pkg::addr_t  addr,
   input  bus_pkg::word_t  busin,
   input  logic            req,
   input  logic            write,
   output bus_pkg::word_t  busout,
   output logic            ack,
   output logic            load,
   output logic            interrupt,
   xbus_if.master          ram,
   xbus_if.master          dma_regs,
   xbus_if.master          io,
   dma_if.arbiter          dma,
   input  logic            irq_dma,
   input  logic            irq_io
);

   bus_pkg::bus_state_t state;
   bus_pkg::bus_state_t next_state;

   logic [TIMEOUT_BITS-1:0] timeout_count;
   logic timed_out;
   logic device_ack;
   logic cpu_cycle;
   logic dma_drop;
   logic dma_ack;

   assign cpu_cycle = req && (state == bus_pkg::bus_req);

   // memory port is shared, the dma master owns it while granted
   assign ram.addr  = (state == bus_pkg::bus_slave) ? dma.addr : addr;
   assign ram.wdata = (state == bus_pkg::bus_slave) ? dma.wdata : busin;
   assign ram.write = (state == bus_pkg::bus_slave) ? dma.write : write;
   assign ram.req   = (state == bus_pkg::bus_slave) ? (dma.req && ram.decode) :
                      (cpu_cycle && ram.decode);

   assign dma_regs.addr  = addr;
   assign dma_regs.wdata = busin;
   assign dma_regs.write = write;
   assign dma_regs.req   = cpu_cycle && dma_regs.decode;

   assign io.addr  = addr;
   assign io.wdata = busin;
   assign io.write = write;
   assign io.req   = cpu_cycle && io.decode;

   // a dma word outside dram is dropped and acked at once
   assign dma_drop = dma.req && !ram.decode;
   assign dma_ack  = (state == bus_pkg::bus_slave) && (ram.ack || dma_drop);

   assign dma.grant = (state == bus_pkg::bus_slave);
   assign dma.ack   = dma_ack;

   assign device_ack = ram.ack | dma_regs.ack | io.ack | timed_out;
   assign ack        = (state == bus_pkg::bus_req) && device_ack;
   assign load       = ack && !write;
   assign interrupt  = irq_dma | irq_io;

   always_comb
   begin
      if (ram.decode)
         busout = ram.rdata;
      else if (dma_regs.decode)
         busout = dma_regs.rdata;
      else if (io.decode)
         busout = io.rdata;
      else if (timed_out)
         busout = '0;
      else
         busout = '1;
   end

   // cpu wins over the dma master when both ask in idle
   always_comb
   begin
      next_state = state;
      unique case (state)
         bus_pkg::bus_idle:
            if (req)
               next_state = bus_pkg::bus_req;
            else if (dma.busreq)
               next_state = bus_pkg::bus_slave;
         bus_pkg::bus_req:
            if (device_ack)
               next_state = bus_pkg::bus_wait;
         bus_pkg::bus_wait:
            if (!req)
               next_state = bus_pkg::bus_idle;
         bus_pkg::bus_slave:
            if (dma_ack)
               next_state = bus_pkg::bus_swait;
            else if (!dma.busreq)
               next_state = bus_pkg::bus_idle;
         bus_pkg::bus_swait:
            // wait for the memory ack to clear before the next word
            if (!ram.ack)
               next_state = dma.busreq ? bus_pkg::bus_slave : bus_pkg::bus_idle;
         default:
            next_state = bus_pkg::bus_idle;
      endcase
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
         state <= bus_pkg::bus_idle;
      else
         state <= next_state;
   end

   // counts only while a cpu request waits for a device
   always_ff @(posedge mclk)
   begin
      if (reset)
         timeout_count <= '0;
      else if (state == bus_pkg::bus_req && !timed_out)
         timeout_count <= timeout_count + 1'b1;
      else if (state != bus_pkg::bus_req)
         timeout_count <= '0;
   end

   assign timed_out = &timeout_count;

endmodule

// ==== design/xbus_if.sv ====
/*
 * xbus_if, dma_if
 * slave bus between the arbiter and each device, and the link
 * through which the dma engine masters the bus
 */

`timescale 1ns/100ps

interface xbus_if;
   bus_pkg::addr_t addr;
   bus_pkg::word_t wdata;
   bus_pkg::word_t rdata;
   logic           req;
   logic           write;
   logic           ack;
   logic           decode;

   modport master (output addr, wdata, req, write, input rdata, ack, decode);
   modport slave  (input addr, wdata, req, write, output rdata, ack, decode);
endinterface

interface dma_if;
   logic           busreq;
   logic           grant;
   bus_pkg::addr_t addr;
   bus_pkg::word_t wdata;
   logic           req;
   logic           write;
   logic           ack;

   modport master  (output busreq, addr, wdata, req, write, input grant, ack);
   modport arbiter (input busreq, addr, wdata, req, write, output grant, ack);
endinterface

// ==== design/addr_map_pkg.sv ====
/*
 * addr_map_pkg
 * address map of the bus, all addresses are word addresses in octal
 * dram at the bottom, dma fill engine and i/o block up in the xbus
 */

package addr_map_pkg;

   // main memory, from 0 up to here
   localparam bus_pkg::addr_t dram_top = 22'o16777777;

   // dma engine, 4 word window
   localparam bus_pkg::addr_t dma_base = 22'o17377770;

   // keyboard and mode register block, 4 word window
   localparam bus_pkg::addr_t io_base = 22'o17772000;

   // dma register offsets
   localparam logic [1:0] dma_cmd     = 2'd0;
   localparam logic [1:0] dma_addr    = 2'd1;
   localparam logic [1:0] dma_count   = 2'd2;
   localparam logic [1:0] dma_pattern = 2'd3;

   // i/o register offsets
   localparam logic [1:0] io_kbdata = 2'd0;
   localparam logic [1:0] io_status = 2'd1;
   localparam logic [1:0] io_mode   = 2'd2;

endpackage

// ==== design/bus_pkg.sv ====
/*
 * bus_pkg
 * common widths and types for the processor bus interface:
 * word address, data word, keyboard code and the arbiter states
 */

package bus_pkg;

   localparam int ADDR_BITS = 22;
   localparam int DATA_BITS = 32;
   localparam int KB_BITS   = 16;

   // word address, 22 bits covers memory and the xbus
   typedef logic [ADDR_BITS-1:0] addr_t;

   typedef logic [DATA_BITS-1:0] word_t;

   typedef logic [KB_BITS-1:0] kb_t;

   // arbiter states
   // req/wait serve the cpu, slave/swait serve the dma master
   typedef enum logic [2:0] {
      bus_idle,
      bus_req,
      bus_wait,
      bus_slave,
      bus_swait
   } bus_state_t;

endpackage
